/* frame_parse.f */
+incdir+test
design/frame_stream_pkg.sv
design/frame_field_pkg.sv
design/field_table_cutter.sv
design/header_field_parser.sv
design/big_field_parser.sv
design/frame_parse_top.sv
test/frame_parse_tb.sv

/* test/frame_parse_vectors.svh */
// Frame row type, row count and the table of frames applied by the testbench

// Columns are name, hdr_en, key_en, len in bytes, seed (byte i = seed + i) and ready_pat
// ready_pat bit n drives out_ready on cycle n of each group of 8 cycles

typedef struct packed {
   logic [127:0] name;
   logic         hdr_en;
   logic         key_en;
   logic [7:0]   len;
   logic [7:0]   seed;
   logic [7:0]   ready_pat;
} frame_vec_t;

localparam int num_vectors = 8;
localparam int name_bytes  = 16;

localparam frame_vec_t vectors [num_vectors] = '{
   // Both parsers on and the payload after byte 22
   '{"long_frame",    1'b1, 1'b1, 8'd40, 8'h10, 8'hFF},

   // Toggling out_ready during the pass-through phase
   '{"back_pressure", 1'b1, 1'b1, 8'd48, 8'hA0, 8'hAA},

   // Header bypassed so the key is bytes 0 to 19
   '{"hdr_disabled",  1'b0, 1'b1, 8'd30, 8'h55, 8'hFF},

   // Fields only with no payload
   '{"exact_fields",  1'b1, 1'b1, 8'd23, 8'h30, 8'hFF},

   // Ends inside the key block
   '{"short_frame",   1'b1, 1'b1, 8'd10, 8'hC0, 8'hFF},

   // Straight after the short frame
   '{"recovery",      1'b1, 1'b1, 8'd26, 8'h77, 8'hCC},

   // Key bypassed so the payload starts at byte 3
   '{"key_disabled",  1'b1, 1'b0, 8'd12, 8'hE8, 8'h6D},

   // Ends inside the header block and leaves the header fields as they were
   '{"hdr_short",     1'b1, 1'b1, 8'd2,  8'h3C, 8'hFF}
};

/* test/frame_parse_tb.sv */
// Frame parser testbench: clock, reset, table driver, output monitor, checks and watchdog
`timescale 1ns/1ps

module frame_parse_tb;

   import frame_stream_pkg::*;
   import frame_field_pkg::*;

   localparam int DSIZE      = dsize_default;
   localparam int KEY_LEN    = 20;
   localparam int KEY_BITS   = KEY_LEN * DSIZE;
   localparam int CLK_PERIOD = 40;

   `include "frame_parse_vectors.svh"

   logic                aclk;
   logic                rst;
   logic                hdr_enable;
   logic                key_enable;
   logic [DSIZE-1:0]    in_data;
   logic                in_valid;
   logic                in_last;
   logic                in_ready;
   logic [DSIZE-1:0]    out_data;
   logic                out_valid;
   logic                out_last;
   logic                out_ready;
   frame_type_t         frame_type;
   frame_length_t       frame_length;
   logic                header_valid;
   logic [KEY_BITS-1:0] key_value;
   logic                key_valid;
   logic                hdr_short;
   logic                key_short;

   // Reference model state, kept across frames like the DUT's published fields
   frame_type_t         exp_type;
   frame_length_t       exp_length;
   logic [KEY_BITS-1:0] exp_key;
   int                  exp_hdr_pulses;
   int                  exp_key_pulses;
   int                  exp_hdr_shorts;
   int                  exp_key_shorts;
   logic [DSIZE-1:0]    exp_out [$];

   // Observed per frame
   logic [DSIZE-1:0]    got_data [$];
   logic                got_last [$];
   int                  hdr_pulses;
   int                  key_pulses;
   int                  hdr_shorts;
   int                  key_shorts;

   logic [7:0]          ready_pat;
   logic [2:0]          ready_phase;
   int                  error_count;
   int                  pass_count;
   int                  fail_count;

   frame_parse_top #(
      .DSIZE   (DSIZE),
      .KEY_LEN (KEY_LEN)
   ) UUT (
      .aclk         (aclk),
      .rst          (rst),
      .hdr_enable   (hdr_enable),
      .key_enable   (key_enable),
      .in_data      (in_data),
      .in_valid     (in_valid),
      .in_last      (in_last),
      .in_ready     (in_ready),
      .out_data     (out_data),
      .out_valid    (out_valid),
      .out_last     (out_last),
      .out_ready    (out_ready),
      .frame_type   (frame_type),
      .frame_length (frame_length),
      .header_valid (header_valid),
      .key_value    (key_value),
      .key_valid    (key_valid),
      .hdr_short    (hdr_short),
      .key_short    (key_short)
   );

   initial begin
      aclk = 1'b0;
      forever #(CLK_PERIOD / 2) aclk = ~aclk;
   end

   // --------------------------------------------------
   // Back-pressure and output monitor
   // --------------------------------------------------

   always @(posedge aclk) begin
      ready_phase <= ready_phase + 3'd1;
      out_ready   <= ready_pat[ready_phase];
   end

   always @(posedge aclk) begin
      if (!rst) begin
         if (out_valid && out_ready) begin
            got_data.push_back(out_data);
            got_last.push_back(out_last);
         end
         if (header_valid) hdr_pulses++;
         if (key_valid) key_pulses++;
         if (hdr_short) hdr_shorts++;
         if (key_short) key_shorts++;
      end
   end

   // --------------------------------------------------
   // Helpers
   // --------------------------------------------------

   function automatic logic [7:0] pattern_byte(input logic [7:0] seed, input int i);
      pattern_byte = (seed + i) & 8'hFF;
   endfunction

   // Drops the zero padding of a packed name
   function automatic string name_text(input logic [127:0] raw);
      string s;
      logic [7:0] c;
      s = "";
      for (int i = name_bytes - 1; i >= 0; i--) begin
         c = raw[8*i +: 8];
         if (c != 8'h00) s = {s, $sformatf("%c", c)};
      end
      return s;
   endfunction

   task automatic check_value(input string test_name, input string what,
                              input logic [KEY_BITS-1:0] expected,
                              input logic [KEY_BITS-1:0] actual);
      assert (actual === expected) else begin
         $display("** Error: %s %s expected %0h actual %0h",
                  test_name, what, expected, actual);
         error_count++;
      end
   endtask

   // Parsing rule: header bytes 0 to 2, then the key, then the payload
   task automatic build_expected(input frame_vec_t v);
      int off;
      int rem;
      exp_out.delete();
      exp_hdr_pulses = 0;
      exp_key_pulses = 0;
      exp_hdr_shorts = 0;
      exp_key_shorts = 0;
      off = 0;
      if (v.hdr_en) begin
         if (v.len >= header_len) begin
            exp_type       = pattern_byte(v.seed, 0);
            exp_length     = {pattern_byte(v.seed, 1), pattern_byte(v.seed, 2)};
            exp_hdr_pulses = 1;
            off            = header_len;
         end else begin
            exp_hdr_shorts = 1;
            off            = v.len;
         end
      end
      rem = v.len - off;
      if (v.key_en && rem > 0) begin
         if (rem >= KEY_LEN) begin
            for (int i = 0; i < KEY_LEN; i++) begin
               exp_key[KEY_BITS-1-DSIZE*i -: DSIZE] = pattern_byte(v.seed, off + i);
            end
            exp_key_pulses = 1;
            off            = off + KEY_LEN;
         end else begin
            exp_key_shorts = 1;
            off            = v.len;
         end
      end
      for (int i = off; i < v.len; i++) begin
         exp_out.push_back(pattern_byte(v.seed, i));
      end
   endtask

   task automatic send_frame(input frame_vec_t v);
      hdr_enable <= v.hdr_en;
      key_enable <= v.key_en;
      for (int i = 0; i < v.len; i++) begin
         in_data  <= pattern_byte(v.seed, i);
         in_valid <= 1'b1;
         in_last  <= (i == v.len - 1);
         do @(posedge aclk); while (!in_ready);
      end
      in_valid <= 1'b0;
      in_last  <= 1'b0;
   endtask

   task automatic check_stream(input string test_name);
      int i;
      check_value(test_name, "output beat count", exp_out.size(), got_data.size());
      for (i = 0; i < got_data.size() && i < exp_out.size(); i++) begin
         check_value(test_name, $sformatf("output byte %0d", i), exp_out[i], got_data[i]);
         check_value(test_name, $sformatf("output last %0d", i),
                     (i == exp_out.size() - 1), got_last[i]);
      end
   endtask

   task automatic run_test(input frame_vec_t v);
      string name;
      int    errors_before;
      name          = name_text(v.name);
      errors_before = error_count;
      build_expected(v);
      got_data.delete();
      got_last.delete();
      hdr_pulses = 0;
      key_pulses = 0;
      hdr_shorts = 0;
      key_shorts = 0;
      ready_pat <= v.ready_pat;
      send_frame(v);
      // field_valid trails the last field byte by 2 cycles
      repeat (4) @(posedge aclk);
      check_value(name, "frame_type", exp_type, frame_type);
      check_value(name, "frame_length", exp_length, frame_length);
      check_value(name, "key_value", exp_key, key_value);
      check_value(name, "header_valid pulses", exp_hdr_pulses, hdr_pulses);
      check_value(name, "key_valid pulses", exp_key_pulses, key_pulses);
      check_value(name, "hdr_short pulses", exp_hdr_shorts, hdr_shorts);
      check_value(name, "key_short pulses", exp_key_shorts, key_shorts);
      check_stream(name);
      if (error_count == errors_before) begin
         pass_count++;
         $display("PASS %s", name);
      end else begin
         fail_count++;
         $display("FAIL %s with %0d errors", name, error_count - errors_before);
      end
   endtask

   // --------------------------------------------------
   // Main sequence and watchdog
   // --------------------------------------------------

   initial begin
      rst         = 1'b1;
      hdr_enable  = 1'b0;
      key_enable  = 1'b0;
      in_data     = '0;
      in_valid    = 1'b0;
      in_last     = 1'b0;
      out_ready   = 1'b1;
      ready_pat   = 8'hFF;
      ready_phase = 3'd0;
      exp_type    = 'x;
      exp_length  = 'x;
      exp_key     = 'x;
      error_count = 0;
      pass_count  = 0;
      fail_count  = 0;
      repeat (4) @(posedge aclk);
      rst <= 1'b0;
      @(posedge aclk);
      for (int t = 0; t < num_vectors; t++) begin
         run_test(vectors[t]);
      end
      $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
               num_vectors, pass_count, fail_count, error_count);
      if (error_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   initial begin
      int total_beats;
      total_beats = 0;
      for (int t = 0; t < num_vectors; t++) begin
         total_beats += vectors[t].len;
      end
      #(total_beats * 4 * CLK_PERIOD);
      $display("Watchdog expired before all frames were processed");
      $display("Test failed");
      $finish;
   end

endmodule

/* design/frame_parse_top.sv */
// Frame parser top: header parser chained into the key parser
`timescale 1ns/1ps

module frame_parse_top #(
   parameter int DSIZE   = frame_stream_pkg::dsize_default,
   parameter int KEY_LEN = 20
) (
   input  logic                           aclk,
   input  logic                           rst,
   input  logic                           hdr_enable,
   input  logic                           key_enable,

   // Frame input
   input  logic [DSIZE-1:0]               in_data,
   input  logic                           in_valid,
   input  logic                           in_last,
   output logic                           in_ready,

   // Payload after both field blocks
   output logic [DSIZE-1:0]               out_data,
   output logic                           out_valid,
   output logic                           out_last,
   input  logic                           out_ready,

   // Header fields
   output frame_field_pkg::frame_type_t   frame_type,
   output frame_field_pkg::frame_length_t frame_length,
   output logic                           header_valid,

   // Key field
   output logic [KEY_LEN*DSIZE-1:0]       key_value,
   output logic                           key_valid,

   // Frames that ended inside a field block
   output logic                           hdr_short,
   output logic                           key_short
);

   // --------------------------------------------------
   // Header to key stream
   // --------------------------------------------------

   logic [DSIZE-1:0] mid_data;
   logic             mid_valid;
   logic             mid_last;
   logic             mid_ready;

   header_field_parser #(
      .DSIZE (DSIZE)
   ) u_header (
      .aclk         (aclk),
      .rst          (rst),
      .enable       (hdr_enable),
      .in_data      (in_data),
      .in_valid     (in_valid),
      .in_last      (in_last),
      .in_ready     (in_ready),
      .out_data     (mid_data),
      .out_valid    (mid_valid),
      .out_last     (mid_last),
      .out_ready    (mid_ready),
      .frame_type   (frame_type),
      .frame_length (frame_length),
      .field_valid  (header_valid),
      .short_frame  (hdr_short)
   );

   // Key follows the header, or starts at byte 0 when the header is bypassed
   big_field_parser #(
      .DSIZE     (DSIZE),
      .FIELD_LEN (KEY_LEN)
   ) u_key (
      .aclk        (aclk),
      .rst         (rst),
      .enable      (key_enable),
      .in_data     (mid_data),
      .in_valid    (mid_valid),
      .in_last     (mid_last),
      .in_ready    (mid_ready),
      .out_data    (out_data),
      .out_valid   (out_valid),
      .out_last    (out_last),
      .out_ready   (out_ready),
      .value       (key_value),
      .field_valid (key_valid),
      .short_frame (key_short)
   );

endmodule

/* design/big_field_parser.sv */
// Wide field parser: cuts a multi-byte key and assembles it left-justified into one value
`timescale 1ns/1ps

module big_field_parser #(
   parameter int DSIZE     = frame_stream_pkg::dsize_default,
   parameter int FIELD_LEN = frame_field_pkg::field_len_max
) (
   input  logic                         aclk,
   input  logic                         rst,
   input  logic                         enable,
   input  logic [DSIZE-1:0]             in_data,
   input  logic                         in_valid,
   input  logic                         in_last,
   output logic                         in_ready,
   output logic [DSIZE-1:0]             out_data,
   output logic                         out_valid,
   output logic                         out_last,
   input  logic                         out_ready,
   output logic [FIELD_LEN*DSIZE-1:0]   value,
   output logic                         field_valid,
   output logic                         short_frame
);

   import frame_field_pkg::*;

   field_index_t byte_index;
   logic         byte_strobe;
   logic         field_done;

   // Key under assembly, the published value is untouched until it completes
   logic [FIELD_LEN*DSIZE-1:0] shadow;

   field_table_cutter #(
      .DSIZE       (DSIZE),
      .FIELD_BYTES (FIELD_LEN)
   ) u_cutter (
      .aclk        (aclk),
      .rst         (rst),
      .enable      (enable),
      .in_data     (in_data),
      .in_valid    (in_valid),
      .in_last     (in_last),
      .in_ready    (in_ready),
      .out_data    (out_data),
      .out_valid   (out_valid),
      .out_last    (out_last),
      .out_ready   (out_ready),
      .byte_strobe (byte_strobe),
      .byte_index  (byte_index),
      .field_done  (field_done),
      .short_frame (short_frame)
   );

   // --------------------------------------------------
   // Byte slot writes
   // --------------------------------------------------

   // First key byte goes to the top slot, later bytes fill downward
   always_ff @(posedge aclk) begin
      if (byte_strobe) begin
         shadow[DSIZE*(FIELD_LEN - 1 - int'(byte_index)) +: DSIZE] <= in_data;
      end
      if (field_done) begin
         value <= shadow;
      end
   end

   always_ff @(posedge aclk) begin
      if (rst) begin
         field_valid <= 1'b0;
      end else begin
         field_valid <= field_done;
      end
   end

endmodule

/* design/header_field_parser.sv */
// Header parser: cuts type and length bytes and publishes them after the block completes
`timescale 1ns/1ps

module header_field_parser #(
   parameter int DSIZE = frame_stream_pkg::dsize_default
) (
   input  logic                           aclk,
   input  logic                           rst,
   input  logic                           enable,
   input  logic [DSIZE-1:0]               in_data,
   input  logic                           in_valid,
   input  logic                           in_last,
   output logic                           in_ready,
   output logic [DSIZE-1:0]               out_data,
   output logic                           out_valid,
   output logic                           out_last,
   input  logic                           out_ready,
   output frame_field_pkg::frame_type_t   frame_type,
   output frame_field_pkg::frame_length_t frame_length,
   output logic                           field_valid,
   output logic                           short_frame
);

   import frame_field_pkg::*;

   field_index_t byte_index;
   logic         byte_strobe;
   logic         field_done;

   // Shadow copies, published only once all header bytes are in
   frame_type_t  type_sh;
   frame_type_t  len_hi_sh;
   frame_type_t  len_lo_sh;

   field_table_cutter #(
      .DSIZE       (DSIZE),
      .FIELD_BYTES (header_len)
   ) u_cutter (
      .aclk        (aclk),
      .rst         (rst),
      .enable      (enable),
      .in_data     (in_data),
      .in_valid    (in_valid),
      .in_last     (in_last),
      .in_ready    (in_ready),
      .out_data    (out_data),
      .out_valid   (out_valid),
      .out_last    (out_last),
      .out_ready   (out_ready),
      .byte_strobe (byte_strobe),
      .byte_index  (byte_index),
      .field_done  (field_done),
      .short_frame (short_frame)
   );

   // Byte 0 type, bytes 1 and 2 big-endian length
   always_ff @(posedge aclk) begin
      if (byte_strobe) begin
         case (byte_index)
            field_index_t'(0): type_sh   <= frame_type_t'(in_data);
            field_index_t'(1): len_hi_sh <= frame_type_t'(in_data);
            default:           len_lo_sh <= frame_type_t'(in_data);
         endcase
      end
      if (field_done) begin
         frame_type   <= type_sh;
         frame_length <= frame_length_t'({len_hi_sh, len_lo_sh});
      end
   end

   always_ff @(posedge aclk) begin
      if (rst) begin
         field_valid <= 1'b0;
      end else begin
         field_valid <= field_done;
      end
   end

endmodule

/* design/field_table_cutter.sv */
// Field cutter FSM: consumes leading field bytes, strobes them, forwards the remainder
`timescale 1ns/1ps

module field_table_cutter #(
   parameter int DSIZE       = frame_stream_pkg::dsize_default,
   parameter int FIELD_BYTES = frame_field_pkg::header_len
) (
   input  logic                          aclk,
   input  logic                          rst,
   input  logic                          enable,
   // Upstream side
   input  logic [DSIZE-1:0]              in_data,
   input  logic                          in_valid,
   input  logic                          in_last,
   output logic                          in_ready,
   // Downstream side
   output logic [DSIZE-1:0]              out_data,
   output logic                          out_valid,
   output logic                          out_last,
   input  logic                          out_ready,
   // Field byte taps
   output logic                          byte_strobe,
   output frame_field_pkg::field_index_t byte_index,
   output logic                          field_done,
   output logic                          short_frame
);

   import frame_stream_pkg::*;
   import frame_field_pkg::*;

   // Index of the final byte of the field block
   localparam beat_count_t LAST_IDX = beat_count_t'(FIELD_BYTES - 1);

   cutter_state_t state;
   beat_count_t   cnt;

   logic frame_start;
   logic field_phase;
   logic pass_phase;
   logic xfer;
   logic at_last_field;

   // --------------------------------------------------
   // Phase decode
   // --------------------------------------------------

   // Counter is only zero in st_field before the first beat
   assign frame_start   = (state == st_field) && (cnt == '0);

   // Enable only matters on the first beat of a frame
   assign field_phase   = (state == st_field) && (!frame_start || enable);

   // A disabled frame passes from its very first beat
   assign pass_phase    = (state == st_pass) || (state == st_bypass) ||
                          (frame_start && !enable);

   assign at_last_field = (cnt == LAST_IDX);

   // Field bytes are sunk here, so out_ready has no say in that phase
   always_comb begin
      if (field_phase) begin
         in_ready = 1'b1;
      end else if (pass_phase) begin
         in_ready = out_ready;
      end else begin
         in_ready = 1'b0;
      end
   end

   assign xfer = in_valid && in_ready;

   // --------------------------------------------------
   // Zero latency forward path
   // --------------------------------------------------

   assign out_valid = pass_phase && in_valid;
   assign out_data  = in_data;
   assign out_last  = in_last;

   // Field byte tap, same cycle as acceptance
   assign byte_strobe = field_phase && in_valid;
   assign byte_index  = cnt[$bits(field_index_t)-1:0];

   // Held for exactly the one cycle spent in st_drop
   assign short_frame = (state == st_drop);

   // --------------------------------------------------
   // FSM and byte counter
   // --------------------------------------------------

   always_ff @(posedge aclk) begin
      if (rst) begin
         state      <= st_field;
         cnt        <= '0;
         field_done <= 1'b0;
      end else begin
         field_done <= xfer && field_phase && at_last_field;

         case (state)
            st_field: begin
               if (xfer) begin
                  if (!field_phase) begin
                     // Disabled frame, single beat frames stay put
                     if (!in_last) begin
                        state <= st_bypass;
                     end
                  end else if (at_last_field) begin
                     cnt <= '0;
                     // A frame may end on its final field byte
                     if (!in_last) begin
                        state <= st_pass;
                     end
                  end else if (in_last) begin
                     // Frame ended inside the field block
                     cnt   <= '0;
                     state <= st_drop;
                  end else begin
                     cnt <= beat_count_t'(cnt + 1'b1);
                  end
               end
            end

            st_pass, st_bypass: begin
               if (xfer && in_last) begin
                  state <= st_field;
               end
            end

            st_drop: begin
               state <= st_field;
            end

            default: begin
               state <= st_field;
               cnt   <= '0;
            end
         endcase
      end
   end

endmodule

/* design/frame_field_pkg.sv */
// Field block limits, field value types and the cutter state encoding

package frame_field_pkg;

   // --------------------------------------------------
   // Field block limits
   // --------------------------------------------------

   // Largest field block a cutter can consume
   localparam int field_len_max = 128;

   // Byte position inside a field block, 0 to 127
   typedef logic [6:0] field_index_t;

   // --------------------------------------------------
   // Frame header layout
   // --------------------------------------------------

   // Type byte followed by a big-endian two byte length
   localparam int header_len = 3;

   typedef logic [7:0]  frame_type_t;
   typedef logic [15:0] frame_length_t;

   // --------------------------------------------------
   // Cutter FSM
   // --------------------------------------------------

   // st_field doubles as the frame start state
   typedef enum logic [1:0] {
      st_field,
      st_pass,
      st_bypass,
      st_drop
   } cutter_state_t;

endpackage

/* design/frame_stream_pkg.sv */
// Stream beat width default, beat data type and in-frame byte counter type

package frame_stream_pkg;

   // --------------------------------------------------
   // Beat width
   // --------------------------------------------------

   // Default beat width in bits, one byte per beat
   localparam int dsize_default = 8;

   // --------------------------------------------------
   // Beat level types
   // --------------------------------------------------

   // One stream beat at the default width
   // Parameterized modules size their data ports from DSIZE instead
   typedef logic [dsize_default-1:0] beat_t;

   // Byte count within a frame, covers up to 256 bytes
   typedef logic [7:0] beat_count_t;

endpackage
